// ==== hdl/snes_bus_pkg.sv ====
// Console-side bus types shared by the bridge RTL and its testbench; import where needed
package snes_bus_pkg;

    // Mapper nibble from the cartridge type byte, bits 7:4
    typedef enum logic [3:0] {
        MAP_STANDARD     = 4'h0,
        MAP_BSRAM_SHARED = 4'hC     // Save RAM answers any enabled access
    } rom_mapper_t;

    typedef struct packed {
        logic [23:0] addr;
        logic        ce_n;
        logic        word;          // 16-bit fetch, no byte swap
    } rom_bus_t;

    typedef struct packed {
        logic [16:0] addr;          // 128 KB work RAM
        logic        ce_n;
        logic        rd_n;
        logic        we_n;
        logic [7:0]  d;
    } wram_bus_t;

    typedef struct packed {
        logic [19:0] addr;
        logic        ce_n;
        logic        rd_n;
        logic        we_n;
        logic [7:0]  d;
    } bsram_bus_t;

    typedef struct packed {
        logic [15:0] addr;          // 64 KB audio RAM
        logic        ce_n;
        logic        oe_n;
        logic        we_n;
        logic [7:0]  d;
    } aram_bus_t;

    // One of these per VRAM port, output enable is common
    typedef struct packed {
        logic [15:0] addr;
        logic        we_n;
        logic [7:0]  d;
    } vram_bus_t;

endpackage

// ==== hdl/sdram_port_pkg.sv ====
// SDRAM controller request types and address constants; import in modules that build requests
package sdram_port_pkg;

    localparam int CPU_ADDR_W  = 23;
    localparam int VRAM_ADDR_W = 15;

    // WRAM lives in banks 7E/7F, the top 128 KB of CPU space
    localparam logic [5:0] WRAM_BANK_PREFIX = 6'b111111;

    // Which source owns the CPU port this cycle
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_LOAD,
        REQ_ROM,
        REQ_WRAM
    } req_kind_t;

    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic                  port;    // 0 ROM or loader, 1 WRAM
        logic [1:0]            ds;      // Byte enables, bit 1 is the high byte
        logic [CPU_ADDR_W-1:0] addr;
        logic [15:0]           din;
    } cpu_req_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [19:0] addr;
        logic [7:0]  din;
    } bsram_req_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [15:0] din;           // Byte repeated in both halves
    } aram_req_t;

    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [VRAM_ADDR_W-1:0] addr;
        logic [7:0]             din;
    } vram_req_t;

endpackage

// ==== hdl/bridge_ctrl.sv ====
// Loader tracking, run-enable gate and phase strobes; instantiated once by the bridge top level
`timescale 1ns/1ps

module bridge_ctrl (
    input  logic        resetn,
    input  logic        wclk,
    input  logic        loading,
    input  logic        loader_valid,
    input  logic        sdram_busy,
    input  logic        frame_pause,
    input  logic        sysclkf_ce,
    input  logic        sysclkr_ce,
    output logic        snes_resetn,
    output logic        enable,
    output logic        f2,
    output logic        r2,
    output logic [23:0] load_addr
);

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_ACTIVE,
        LOAD_DONE
    } load_state_t;

    load_state_t state;
    load_state_t state_next;
    logic        loaded;
    logic        load_start;

    // Rising edge of loading, seen from any state but ACTIVE
    assign load_start  = loading && (state != LOAD_ACTIVE);
    assign loaded      = (state == LOAD_DONE);
    assign snes_resetn = resetn & ~loading;     // Console held in reset during a load

    always_comb begin
        state_next = state;
        unique case (state)
            LOAD_IDLE: begin
                if (loading)
                    state_next = LOAD_ACTIVE;
            end
            LOAD_ACTIVE: begin
                if (!loading)
                    state_next = LOAD_DONE;
            end
            LOAD_DONE: begin
                if (loading)
                    state_next = LOAD_ACTIVE;   // New image replaces the old one
            end
            default: state_next = LOAD_IDLE;
        endcase
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            state     <= LOAD_IDLE;
            load_addr <= '0;
        end else begin
            state <= state_next;
            if (load_start)
                load_addr <= '0;
            else if (loader_valid)
                load_addr <= load_addr + 24'd1;
        end
    end

    // Run permission, then the gated phase pulses one cycle behind it
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
            f2     <= 1'b0;
            r2     <= 1'b0;
        end else begin
            enable <= ~sdram_busy & ~frame_pause & loaded;
            f2     <= sysclkf_ce & enable;  // Fall phase
            r2     <= sysclkr_ce & enable;  // Rise phase
        end
    end

endmodule

// ==== hdl/sdram_request_mux.sv ====
// Builds SDRAM requests for the CPU, save RAM and audio RAM ports; instantiated by the bridge top
`timescale 1ns/1ps

module sdram_request_mux (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      f2,
    input  logic                      r2,
    input  logic                      loading,
    input  logic                      loader_valid,
    input  logic [7:0]                loader_data,
    input  logic [23:0]               load_addr,
    input  snes_bus_pkg::rom_mapper_t mapper,
    input  snes_bus_pkg::rom_bus_t    rom,
    input  snes_bus_pkg::wram_bus_t   wram,
    input  snes_bus_pkg::bsram_bus_t  bsram,
    input  snes_bus_pkg::aram_bus_t   aram,
    output sdram_port_pkg::cpu_req_t   cpu_req,
    output sdram_port_pkg::bsram_req_t bsram_req,
    output sdram_port_pkg::aram_req_t  aram_req
);

    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    req_kind_t  kind;
    cpu_req_t   cpu_next;
    bsram_req_t bsram_next;
    logic       bsram_rd_t;
    logic       wram_rd;
    logic       wram_wr;

    // Shared-mapper save RAM reads without a read strobe
    assign bsram_rd_t = ~bsram.ce_n & f2 &
                        (~bsram.rd_n | (mapper == MAP_BSRAM_SHARED));
    assign wram_rd    = ~wram.ce_n & ~wram.rd_n;
    assign wram_wr    = ~wram.ce_n & ~wram.we_n;

    // CPU port priority
    always_comb begin
        if (loading && loader_valid)
            kind = REQ_LOAD;
        else if (!rom.ce_n && f2 && !bsram_rd_t)
            kind = REQ_ROM;
        else if (wram_rd || wram_wr)
            kind = REQ_WRAM;
        else
            kind = REQ_NONE;
    end

    always_comb begin
        cpu_next = '0;
        unique case (kind)
            REQ_LOAD: begin
                cpu_next.wr   = 1'b1;
                cpu_next.addr = load_addr[CPU_ADDR_W-1:0];
                cpu_next.ds   = {load_addr[0], ~load_addr[0]};
                cpu_next.din  = {loader_data, loader_data};
            end
            REQ_ROM: begin
                cpu_next.rd   = 1'b1;
                cpu_next.addr = rom.addr[CPU_ADDR_W-1:0];
                cpu_next.ds   = 2'b11;      // Full word, steer picks the byte
            end
            REQ_WRAM: begin
                cpu_next.rd   = wram_rd & f2;
                cpu_next.wr   = wram_wr & r2;
                cpu_next.port = 1'b1;
                cpu_next.addr = {WRAM_BANK_PREFIX, wram.addr};
                cpu_next.ds   = {wram.addr[0], ~wram.addr[0]};
                cpu_next.din  = {wram.d, wram.d};
            end
            default: cpu_next = '0;
        endcase
    end

    always_comb begin
        bsram_next.rd   = bsram_rd_t;
        bsram_next.wr   = ~bsram.ce_n & ~bsram.we_n & r2;
        bsram_next.addr = bsram.addr;
        bsram_next.din  = bsram.d;
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_req   <= '0;
            bsram_req <= '0;
        end else begin
            cpu_req   <= cpu_next;
            bsram_req <= bsram_next;
        end
    end

    // Audio RAM goes straight through in the same cycle
    always_comb begin
        aram_req.rd   = ~aram.ce_n & ~aram.oe_n;
        aram_req.wr   = ~aram.ce_n & ~aram.we_n;
        aram_req.addr = aram.addr;
        aram_req.din  = {aram.d, aram.d};
    end

endmodule

// ==== hdl/read_data_steer.sv ====
// Routes returned SDRAM words to the byte-wide console buses; instantiated by the bridge top
`timescale 1ns/1ps

module read_data_steer (
    input  logic                      wclk,
    input  logic                      resetn,
    input  snes_bus_pkg::rom_bus_t    rom,
    input  logic                      wram_addr_lsb,
    input  sdram_port_pkg::aram_req_t aram_req,
    input  logic [15:0]               port0,
    input  logic [15:0]               port1,
    input  logic [15:0]               aram_dout,
    output logic [15:0]               rom_q,
    output logic [7:0]                wram_q,
    output logic [7:0]                aram_q
);

    logic aram_lsb;     // Byte asked for by the last ARAM read

    // Odd byte fetch puts the wanted byte in the low half
    assign rom_q = (rom.word || !rom.addr[0]) ? port0 : {port0[7:0], port0[15:8]};

    assign wram_q = wram_addr_lsb ? port1[15:8] : port1[7:0];

    always_ff @(posedge wclk) begin
        if (!resetn)
            aram_lsb <= 1'b0;
        else if (aram_req.rd)
            aram_lsb <= aram_req.addr[0];
    end

    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

endmodule

// ==== hdl/vram_read_filter.sv ====
// Drops repeated VRAM reads and staggers dual-port reads; instantiated by the bridge top
`timescale 1ns/1ps

module vram_read_filter (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      vram_oe_n,
    input  snes_bus_pkg::vram_bus_t   vram1,
    input  snes_bus_pkg::vram_bus_t   vram2,
    output sdram_port_pkg::vram_req_t vram1_req,
    output sdram_port_pkg::vram_req_t vram2_req
);

    import sdram_port_pkg::*;

    logic                   oe_n_old;
    logic [VRAM_ADDR_W-1:0] addr1_old;
    logic [VRAM_ADDR_W-1:0] addr2_old;
    logic                   delay_r;
    logic                   new_read1;
    logic                   new_read2;
    logic                   delay2;

    assign new_read1 = ~vram_oe_n &
                       (oe_n_old | (addr1_old != vram1.addr[VRAM_ADDR_W-1:0]));
    assign new_read2 = ~vram_oe_n &
                       (oe_n_old | (addr2_old != vram2.addr[VRAM_ADDR_W-1:0]));

    // Both ports want different words, port 2 waits a cycle
    assign delay2 = new_read1 & new_read2 & (vram1.addr != vram2.addr);

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            oe_n_old  <= 1'b1;
            addr1_old <= '0;
            addr2_old <= '0;
            delay_r   <= 1'b0;
        end else begin
            oe_n_old  <= vram_oe_n;
            addr1_old <= vram1.addr[VRAM_ADDR_W-1:0];
            addr2_old <= vram2.addr[VRAM_ADDR_W-1:0];
            delay_r   <= delay2;
        end
    end

    always_comb begin
        vram1_req.rd   = new_read1;
        vram1_req.wr   = ~vram1.we_n;
        vram1_req.addr = vram1.addr[VRAM_ADDR_W-1:0];
        vram1_req.din  = vram1.d;

        vram2_req.rd   = (new_read2 & ~delay2) | delay_r;
        vram2_req.wr   = ~vram2.we_n;
        vram2_req.addr = vram2.addr[VRAM_ADDR_W-1:0];   // Still held from the delayed cycle
        vram2_req.din  = vram2.d;
    end

endmodule

// ==== hdl/snes_mem_bridge.sv ====
// Top level of the console-to-SDRAM memory bridge; connects control and datapath blocks
`timescale 1ns/1ps

module snes_mem_bridge (
    input  logic                       wclk,
    input  logic                       resetn,
    input  logic                       loading,
    input  logic                       loader_valid,
    input  logic [7:0]                 loader_data,
    input  logic                       sdram_busy,
    input  logic                       frame_pause,
    input  logic                       sysclkf_ce,
    input  logic                       sysclkr_ce,
    input  snes_bus_pkg::rom_mapper_t  mapper,
    input  snes_bus_pkg::rom_bus_t     rom,
    input  snes_bus_pkg::wram_bus_t    wram,
    input  snes_bus_pkg::bsram_bus_t   bsram,
    input  snes_bus_pkg::aram_bus_t    aram,
    input  snes_bus_pkg::vram_bus_t    vram1,
    input  snes_bus_pkg::vram_bus_t    vram2,
    input  logic                       vram_oe_n,
    input  logic [15:0]                port0,
    input  logic [15:0]                port1,
    input  logic [15:0]                aram_dout,
    output logic                       snes_resetn,
    output logic                       enable,
    output sdram_port_pkg::cpu_req_t   cpu_req,
    output sdram_port_pkg::bsram_req_t bsram_req,
    output sdram_port_pkg::aram_req_t  aram_req,
    output sdram_port_pkg::vram_req_t  vram1_req,
    output sdram_port_pkg::vram_req_t  vram2_req,
    output logic [15:0]                rom_q,
    output logic [7:0]                 wram_q,
    output logic [7:0]                 aram_q
);

    logic        f2;
    logic        r2;
    logic [23:0] load_addr;    // Next byte position in the ROM image

    bridge_ctrl u_ctrl (
        .resetn       (resetn),
        .wclk         (wclk),
        .loading      (loading),
        .loader_valid (loader_valid),
        .sdram_busy   (sdram_busy),
        .frame_pause  (frame_pause),
        .sysclkf_ce   (sysclkf_ce),
        .sysclkr_ce   (sysclkr_ce),
        .snes_resetn  (snes_resetn),
        .enable       (enable),
        .f2           (f2),
        .r2           (r2),
        .load_addr    (load_addr)
    );

    sdram_request_mux u_req_mux (
        .wclk         (wclk),
        .resetn       (resetn),
        .f2           (f2),
        .r2           (r2),
        .loading      (loading),
        .loader_valid (loader_valid),
        .loader_data  (loader_data),
        .load_addr    (load_addr),
        .mapper       (mapper),
        .rom          (rom),
        .wram         (wram),
        .bsram        (bsram),
        .aram         (aram),
        .cpu_req      (cpu_req),
        .bsram_req    (bsram_req),
        .aram_req     (aram_req)
    );

    read_data_steer u_steer (
        .wclk          (wclk),
        .resetn        (resetn),
        .rom           (rom),
        .wram_addr_lsb (wram.addr[0]),
        .aram_req      (aram_req),
        .port0         (port0),
        .port1         (port1),
        .aram_dout     (aram_dout),
        .rom_q         (rom_q),
        .wram_q        (wram_q),
        .aram_q        (aram_q)
    );

    vram_read_filter u_vram_filter (
        .wclk      (wclk),
        .resetn    (resetn),
        .vram_oe_n (vram_oe_n),
        .vram1     (vram1),
        .vram2     (vram2),
        .vram1_req (vram1_req),
        .vram2_req (vram2_req)
    );

endmodule

// ==== sim/tb_checks.svh ====
// Compare tasks and the stop routine for the bridge testbench; included inside the testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Ends the run after a failure has been described
task automatic stop_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
endtask

task automatic check_cpu_req(string name, sdram_port_pkg::cpu_req_t exp,
                             sdram_port_pkg::cpu_req_t act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_bsram_req(string name, sdram_port_pkg::bsram_req_t exp,
                               sdram_port_pkg::bsram_req_t act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_aram_req(string name, sdram_port_pkg::aram_req_t exp,
                              sdram_port_pkg::aram_req_t act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_vram_req(string name, sdram_port_pkg::vram_req_t exp,
                              sdram_port_pkg::vram_req_t act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

`endif

// ==== sim/tb_snes_mem_bridge.sv ====
// Directed testbench for the memory bridge; run as the simulation top with the project file list
`timescale 1ns/1ps

module tb_snes_mem_bridge;

    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    `include "tb_checks.svh"

    localparam int TIMEOUT_CYCLES = 2000;

    logic        wclk;
    logic        resetn;
    logic        loading;
    logic        loader_valid;
    logic [7:0]  loader_data;
    logic        sdram_busy;
    logic        frame_pause;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    rom_mapper_t mapper;
    rom_bus_t    rom;
    wram_bus_t   wram;
    bsram_bus_t  bsram;
    aram_bus_t   aram;
    vram_bus_t   vram1;
    vram_bus_t   vram2;
    logic        vram_oe_n;
    logic [15:0] port0;
    logic [15:0] port1;
    logic [15:0] aram_dout;
    logic        snes_resetn;
    logic        enable;
    cpu_req_t    cpu_req;
    bsram_req_t  bsram_req;
    aram_req_t   aram_req;
    vram_req_t   vram1_req;
    vram_req_t   vram2_req;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic [7:0]  aram_q;
    int          cycles;

    snes_mem_bridge dut (.*);

    initial begin
        wclk = 1'b0;
        forever #20 wclk = ~wclk;
    end

    always @(posedge wclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // Next rising edge plus drive delay
    task automatic tick();
        @(posedge wclk);
        #2;
    endtask

    task automatic pulse_f();
        sysclkf_ce = 1'b1;
        tick();
        sysclkf_ce = 1'b0;
    endtask

    task automatic pulse_r();
        sysclkr_ce = 1'b1;
        tick();
        sysclkr_ce = 1'b0;
    endtask

    function automatic cpu_req_t load_expect(logic [22:0] addr, logic [7:0] data);
        cpu_req_t e;
        e      = '0;
        e.wr   = 1'b1;
        e.addr = addr;
        e.ds   = addr[0] ? 2'b10 : 2'b01;
        e.din  = {data, data};
        return e;
    endfunction

    function automatic cpu_req_t wram_expect(logic [16:0] addr, logic [7:0] d,
                                             logic rd, logic wr);
        cpu_req_t e;
        e      = '0;
        e.rd   = rd;
        e.wr   = wr;
        e.port = 1'b1;
        e.addr = {6'b111111, addr};     // Banks 7E and 7F
        e.ds   = addr[0] ? 2'b10 : 2'b01;
        e.din  = {d, d};
        return e;
    endfunction

    task automatic test_loading();
        logic [7:0] data;
        loading = 1'b1;
        #1;
        check_byte("snes_resetn", 8'd0, {7'd0, snes_resetn});
        tick();
        for (int i = 0; i < 6; i++) begin
            data         = 8'($urandom());
            loader_valid = 1'b1;
            loader_data  = data;
            tick();
            check_cpu_req("cpu_req", load_expect(23'(i), data), cpu_req);
        end
        loader_valid = 1'b0;
        loading      = 1'b0;
        tick();
        check_byte("loaded", 8'd1, {7'd0, dut.u_ctrl.loaded});
        tick();
        check_byte("enable", 8'd1, {7'd0, enable});
    endtask

    task automatic test_rom();
        cpu_req_t   e;
        logic [23:0] a;
        a        = 24'($urandom());
        rom.addr = a;
        rom.ce_n = 1'b0;
        pulse_f();
        tick();
        e      = '0;
        e.rd   = 1'b1;
        e.ds   = 2'b11;
        e.addr = a[22:0];
        check_cpu_req("cpu_req", e, cpu_req);
        rom.ce_n = 1'b1;
        port0    = 16'($urandom());
        rom.addr = {a[23:1], 1'b0};
        #1;
        check_word("rom_q", port0, rom_q);
        rom.addr = {a[23:1], 1'b1};
        #1;
        check_word("rom_q", {port0[7:0], port0[15:8]}, rom_q);
        tick();
    endtask

    task automatic test_wram();
        logic [16:0] a;
        logic [7:0]  d;
        a         = 17'($urandom());
        d         = 8'($urandom());
        wram.addr = a;
        wram.d    = d;
        wram.ce_n = 1'b0;
        wram.rd_n = 1'b0;
        tick();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b0, 1'b0), cpu_req);  // No f phase yet
        pulse_f();
        tick();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b1, 1'b0), cpu_req);
        wram.rd_n = 1'b1;
        wram.we_n = 1'b0;
        tick();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b0, 1'b0), cpu_req);
        pulse_r();
        tick();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b0, 1'b1), cpu_req);
        wram.ce_n = 1'b1;
        wram.we_n = 1'b1;
        port1     = 16'($urandom());
        #1;
        check_byte("wram_q", a[0] ? port1[15:8] : port1[7:0], wram_q);
        tick();
    endtask

    task automatic test_bsram();
        bsram_req_t e;
        e          = '0;
        e.addr     = 20'($urandom());
        e.din      = 8'($urandom());
        bsram.addr = e.addr;
        bsram.d    = e.din;
        bsram.ce_n = 1'b0;
        bsram.rd_n = 1'b0;
        pulse_f();
        tick();
        e.rd = 1'b1;
        check_bsram_req("bsram_req", e, bsram_req);
        bsram.rd_n = 1'b1;
        bsram.we_n = 1'b0;
        pulse_r();
        tick();
        e.rd = 1'b0;
        e.wr = 1'b1;
        check_bsram_req("bsram_req", e, bsram_req);
        // Shared mapper reads with rd_n high and keeps ROM off the CPU port
        bsram.we_n = 1'b1;
        mapper     = MAP_BSRAM_SHARED;
        rom.ce_n   = 1'b0;
        pulse_f();
        tick();
        e.rd = 1'b1;
        e.wr = 1'b0;
        check_bsram_req("bsram_req", e, bsram_req);
        check_cpu_req("cpu_req", '0, cpu_req);
        rom.ce_n   = 1'b1;
        bsram.ce_n = 1'b1;
        mapper     = MAP_STANDARD;
        tick();
    endtask

    task automatic test_vram_aram();
        vram_req_t   e1;
        vram_req_t   e2;
        aram_req_t   ea;
        logic [15:0] b;
        logic        lsb;
        b          = 16'($urandom());
        vram1.addr = b;
        vram2.addr = b;
        vram_oe_n  = 1'b0;
        #1;
        e1 = '{rd: 1'b1, wr: 1'b0, addr: b[14:0], din: vram1.d};
        e2 = '{rd: 1'b1, wr: 1'b0, addr: b[14:0], din: vram2.d};
        check_vram_req("vram1_req", e1, vram1_req);
        check_vram_req("vram2_req", e2, vram2_req);
        tick();
        e1.rd = 1'b0;
        e2.rd = 1'b0;
        check_vram_req("vram1_req", e1, vram1_req);     // Same address again
        check_vram_req("vram2_req", e2, vram2_req);
        vram_oe_n = 1'b1;
        tick();
        vram1.addr = b;
        vram2.addr = b ^ 16'h0001;
        vram_oe_n  = 1'b0;
        #1;
        e1 = '{rd: 1'b1, wr: 1'b0, addr: b[14:0], din: vram1.d};
        e2 = '{rd: 1'b0, wr: 1'b0, addr: vram2.addr[14:0], din: vram2.d};
        check_vram_req("vram1_req", e1, vram1_req);
        check_vram_req("vram2_req", e2, vram2_req);
        tick();
        e1.rd = 1'b0;
        e2.rd = 1'b1;
        check_vram_req("vram1_req", e1, vram1_req);
        check_vram_req("vram2_req", e2, vram2_req);
        tick();
        e2.rd = 1'b0;
        check_vram_req("vram2_req", e2, vram2_req);
        vram_oe_n = 1'b1;
        for (int k = 0; k < 2; k++) begin
            aram.addr = {15'($urandom()), k[0] ^ 1'b1};
            aram.d    = 8'($urandom());
            aram.ce_n = 1'b0;
            aram.oe_n = 1'b0;
            #1;
            ea = '{rd: 1'b1, wr: 1'b0, addr: aram.addr, din: {aram.d, aram.d}};
            check_aram_req("aram_req", ea, aram_req);
            lsb = aram.addr[0];
            tick();
            aram.ce_n    = 1'b1;
            aram.oe_n    = 1'b1;
            aram.addr[0] = ~lsb;    // Bus moves on while the word comes back
            aram_dout    = 16'($urandom());
            #1;
            check_byte("aram_q", lsb ? aram_dout[15:8] : aram_dout[7:0], aram_q);
            tick();
        end
    endtask

    task automatic test_gating();
        bsram_req_t  e;
        logic [16:0] a;
        logic [7:0]  d;
        sdram_busy = 1'b1;
        tick();
        check_byte("enable", 8'd0, {7'd0, enable});
        sdram_busy = 1'b0;
        tick();
        tick();
        check_byte("enable", 8'd1, {7'd0, enable});
        frame_pause = 1'b1;
        tick();
        check_byte("enable", 8'd0, {7'd0, enable});
        // ROM read, WRAM write and save RAM write all wait for a phase
        a          = 17'($urandom());
        d          = 8'($urandom());
        wram.addr  = a;
        wram.d     = d;
        wram.ce_n  = 1'b0;
        wram.we_n  = 1'b0;
        e          = '0;
        e.addr     = 20'($urandom());
        e.din      = 8'($urandom());
        bsram.addr = e.addr;
        bsram.d    = e.din;
        bsram.ce_n = 1'b0;
        bsram.we_n = 1'b0;
        rom.ce_n   = 1'b0;
        pulse_f();
        pulse_r();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b0, 1'b0), cpu_req);
        check_bsram_req("bsram_req", e, bsram_req);
        tick();
        check_cpu_req("cpu_req", wram_expect(a, d, 1'b0, 1'b0), cpu_req);
        check_bsram_req("bsram_req", e, bsram_req);
        wram.ce_n   = 1'b1;
        wram.we_n   = 1'b1;
        bsram.ce_n  = 1'b1;
        bsram.we_n  = 1'b1;
        rom.ce_n    = 1'b1;
        frame_pause = 1'b0;
        tick();
    endtask

    task automatic test_priority();
        logic [7:0] data;
        data    = 8'($urandom());
        loading = 1'b1;
        tick();
        loader_valid = 1'b1;
        loader_data  = data;
        wram.addr    = 17'($urandom());
        wram.ce_n    = 1'b0;
        wram.we_n    = 1'b0;
        tick();
        check_cpu_req("cpu_req", load_expect(23'd0, data), cpu_req);
        loader_valid = 1'b0;
        loading      = 1'b0;
        wram.ce_n    = 1'b1;
        wram.we_n    = 1'b1;
        tick();
        tick();
        check_byte("enable", 8'd1, {7'd0, enable});
    endtask

    initial begin
        void'($urandom(46527));
        cycles       = 0;
        resetn       = 1'b0;
        loading      = 1'b0;
        loader_valid = 1'b0;
        loader_data  = '0;
        sdram_busy   = 1'b0;
        frame_pause  = 1'b0;
        sysclkf_ce   = 1'b0;
        sysclkr_ce   = 1'b0;
        mapper       = MAP_STANDARD;
        rom          = '{addr: '0, ce_n: 1'b1, word: 1'b0};
        wram         = '{addr: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1, d: '0};
        bsram        = '{addr: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1, d: '0};
        aram         = '{addr: '0, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1, d: '0};
        vram1        = '{addr: '0, we_n: 1'b1, d: '0};
        vram2        = '{addr: '0, we_n: 1'b1, d: '0};
        vram_oe_n    = 1'b1;
        port0        = '0;
        port1        = '0;
        aram_dout    = '0;
        repeat (10) tick();
        resetn = 1'b1;
        tick();
        test_loading();
        test_rom();
        test_wram();
        test_bsram();
        test_vram_aram();
        test_gating();
        test_priority();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== snes_mem_bridge.f ====
+incdir+sim
hdl/snes_bus_pkg.sv
hdl/sdram_port_pkg.sv
hdl/bridge_ctrl.sv
hdl/sdram_request_mux.sv
hdl/read_data_steer.sv
hdl/vram_read_filter.sv
hdl/snes_mem_bridge.sv
sim/tb_snes_mem_bridge.sv

// ==== Makefile ====
# Verilator flow for the memory bridge testbench

TOP := tb_snes_mem_bridge
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f snes_mem_bridge.f --top-module snes_mem_bridge
	verilator --lint-only --timing -f snes_mem_bridge.f --top-module $(TOP)

sim:
	verilator --binary --timing -f snes_mem_bridge.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
